// File: verilog/valu_pkg.sv
/* Vector ALU shared definitions
   Register and lane widths, opcode and class encodings, issue packet */
package valu_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int VLEN  = 64;
    localparam int LLEN  = 32;
    localparam int LANES = VLEN / LLEN;

    typedef logic [VLEN-1:0] vec_t;
    typedef logic [LLEN-1:0] lane_t;
    typedef logic [31:0]     scalar_t;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_e;

    typedef enum logic [4:0] {
        VADD_VV     = 5'd0,
        VADD_VX     = 5'd1,
        VSUB_VV     = 5'd2,
        VSUB_VX     = 5'd3,
        VAND_VV     = 5'd4,
        VOR_VV      = 5'd5,
        VXOR_VV     = 5'd6,
        VMIN_VV     = 5'd7,
        VMAX_VV     = 5'd8,
        VMUL_VV     = 5'd9,
        VMV_VV      = 5'd10,
        VMV_VX      = 5'd11,
        VREDSUM     = 5'd12,
        VREDAND     = 5'd13,
        VREDOR      = 5'd14,
        VREDXOR     = 5'd15,
        VSLIDE1UP   = 5'd16,
        VSLIDE1DOWN = 5'd17
    } valu_op_e;

    // Normalized function, also selects the reduction fold
    typedef enum logic [2:0] {
        L_ADD = 3'd0,
        L_SUB = 3'd1,
        L_AND = 3'd2,
        L_OR  = 3'd3,
        L_XOR = 3'd4,
        L_MIN = 3'd5,
        L_MAX = 3'd6,
        L_MUL = 3'd7
    } lane_op_e;

    typedef enum logic [1:0] {
        C_LANE   = 2'd0,
        C_MOVE   = 2'd1,
        C_REDUCE = 2'd2,
        C_SLIDE  = 2'd3
    } op_class_e;

    // Issue to execute packet
    typedef struct packed {
        logic      valid;
        op_class_e op_class;
        lane_op_e  lane_op;
        lane_op_e  red_op;
        logic      slide_up;
        sew_e      sew;
        vec_t      first_operand;
        vec_t      second_operand;
        scalar_t   scalar;
    } issue_pkt_t;

endpackage

// File: verilog/valu_lane.sv
/* Vector ALU lane
   Element-width aware arithmetic, logic, min/max and low multiply on one slice */
`timescale 1ns/1ns

module valu_lane (
    input  valu_pkg::lane_op_e lane_op_i,
    input  valu_pkg::sew_e     sew_i,
    input  valu_pkg::lane_t    first_i,
    input  valu_pkg::lane_t    second_i,
    output valu_pkg::lane_t    result_o
);

    valu_pkg::lane_t res8;
    valu_pkg::lane_t res16;
    valu_pkg::lane_t res32;

    // Operands arrive sign extended from the element width, so the low
    // element bits of every result are exact and min/max compare correctly
    function automatic valu_pkg::lane_t elem_fn(
        input valu_pkg::lane_op_e op,
        input logic signed [31:0] a,
        input logic signed [31:0] b
    );
        case (op)
            valu_pkg::L_ADD: return a + b;
            valu_pkg::L_SUB: return a - b;
            valu_pkg::L_AND: return a & b;
            valu_pkg::L_OR:  return a | b;
            valu_pkg::L_XOR: return a ^ b;
            valu_pkg::L_MIN: return (a < b) ? a : b;
            valu_pkg::L_MAX: return (a > b) ? a : b;
            default:         return a * b;
        endcase
    endfunction

    ////////////////////////////////////////
    // Four 8-bit elements
    ////////////////////////////////////////
    always_comb begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] t;

        res8 = '0;
        for (int i = 0; i < 4; i++) begin
            a = {{24{first_i[8*i+7]}}, first_i[8*i +: 8]};
            b = {{24{second_i[8*i+7]}}, second_i[8*i +: 8]};
            t = elem_fn(lane_op_i, a, b);
            res8[8*i +: 8] = t[7:0];
        end
    end

    ////////////////////////////////////////
    // Two 16-bit elements
    ////////////////////////////////////////
    always_comb begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] t;

        res16 = '0;
        for (int i = 0; i < 2; i++) begin
            a = {{16{first_i[16*i+15]}}, first_i[16*i +: 16]};
            b = {{16{second_i[16*i+15]}}, second_i[16*i +: 16]};
            t = elem_fn(lane_op_i, a, b);
            res16[16*i +: 16] = t[15:0];
        end
    end

    // One 32-bit element
    assign res32 = elem_fn(lane_op_i, first_i, second_i);

    always_comb begin
        case (sew_i)
            valu_pkg::SEW8:  result_o = res8;
            valu_pkg::SEW16: result_o = res16;
            default:         result_o = res32;
        endcase
    end

endmodule

// File: verilog/valu_reduce.sv
/* Vector ALU reduction unit
   Folds every element of one register into the scalar seed */
`timescale 1ns/1ns

module valu_reduce (
    input  valu_pkg::lane_op_e red_op_i,
    input  valu_pkg::sew_e     sew_i,
    input  valu_pkg::vec_t     vector_i,
    input  valu_pkg::scalar_t  seed_i,
    output valu_pkg::vec_t     result_o
);

    valu_pkg::scalar_t acc8;
    valu_pkg::scalar_t acc16;
    valu_pkg::scalar_t acc32;

    // Upper bits may carry junk from the sum, only the low sew bits are kept
    function automatic valu_pkg::scalar_t fold(
        input valu_pkg::lane_op_e op,
        input valu_pkg::scalar_t  acc,
        input valu_pkg::scalar_t  elem
    );
        case (op)
            valu_pkg::L_AND: return acc & elem;
            valu_pkg::L_OR:  return acc | elem;
            valu_pkg::L_XOR: return acc ^ elem;
            default:         return acc + elem;
        endcase
    endfunction

    ////////////////////////////////////////
    // Per width fold chains
    ////////////////////////////////////////
    always_comb begin
        acc8 = {24'd0, seed_i[7:0]};
        for (int i = 0; i < valu_pkg::VLEN/8; i++) begin
            acc8 = fold(red_op_i, acc8, {24'd0, vector_i[8*i +: 8]});
        end
    end

    always_comb begin
        acc16 = {16'd0, seed_i[15:0]};
        for (int i = 0; i < valu_pkg::VLEN/16; i++) begin
            acc16 = fold(red_op_i, acc16, {16'd0, vector_i[16*i +: 16]});
        end
    end

    always_comb begin
        acc32 = seed_i;
        for (int i = 0; i < valu_pkg::VLEN/32; i++) begin
            acc32 = fold(red_op_i, acc32, vector_i[32*i +: 32]);
        end
    end

    // Element 0 only, rest of the register cleared
    always_comb begin
        result_o = '0;
        case (sew_i)
            valu_pkg::SEW8:  result_o[7:0]  = acc8[7:0];
            valu_pkg::SEW16: result_o[15:0] = acc16[15:0];
            default:         result_o[31:0] = acc32;
        endcase
    end

endmodule

// File: verilog/valu_slide.sv
/* Vector ALU slide unit
   Slide one element up or down with the scalar filling the vacated end */
`timescale 1ns/1ns

module valu_slide (
    input  logic              slide_up_i,
    input  valu_pkg::sew_e    sew_i,
    input  valu_pkg::vec_t    vector_i,
    input  valu_pkg::scalar_t scalar_i,
    output valu_pkg::vec_t    result_o
);

    valu_pkg::vec_t up;
    valu_pkg::vec_t down;

    // Up moves element i to i+1, down moves i+1 to i
    always_comb begin
        case (sew_i)
            valu_pkg::SEW8: begin
                up   = {vector_i[valu_pkg::VLEN-9:0], scalar_i[7:0]};
                down = {scalar_i[7:0], vector_i[valu_pkg::VLEN-1:8]};
            end
            valu_pkg::SEW16: begin
                up   = {vector_i[valu_pkg::VLEN-17:0], scalar_i[15:0]};
                down = {scalar_i[15:0], vector_i[valu_pkg::VLEN-1:16]};
            end
            default: begin
                up   = {vector_i[valu_pkg::VLEN-33:0], scalar_i};
                down = {scalar_i, vector_i[valu_pkg::VLEN-1:32]};
            end
        endcase
    end

    assign result_o = slide_up_i ? up : down;

endmodule

// File: verilog/valu_issue.sv
/* Vector ALU issue stage
   Opcode decode, scalar broadcast and the issue packet register */
`timescale 1ns/1ns

module valu_issue (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 valid_i,
    input  valu_pkg::valu_op_e   op_i,
    input  valu_pkg::sew_e       sew_i,
    input  valu_pkg::vec_t       first_operand_i,
    input  valu_pkg::vec_t       second_operand_i,
    input  valu_pkg::scalar_t    scalar_i,
    output valu_pkg::issue_pkt_t pkt_o
);

    valu_pkg::vec_t       scalar_bcast;
    logic                 use_scalar;
    valu_pkg::issue_pkt_t pkt_d;
    valu_pkg::issue_pkt_t pkt_q;
    logic                 valid_q;

    // Low sew bits of the scalar copied into every element
    always_comb begin
        case (sew_i)
            valu_pkg::SEW8:  scalar_bcast = {(valu_pkg::VLEN/8){scalar_i[7:0]}};
            valu_pkg::SEW16: scalar_bcast = {(valu_pkg::VLEN/16){scalar_i[15:0]}};
            default:         scalar_bcast = {(valu_pkg::VLEN/32){scalar_i}};
        endcase
    end

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////
    always_comb begin
        pkt_d          = '0;
        pkt_d.op_class = valu_pkg::C_LANE;
        pkt_d.lane_op  = valu_pkg::L_ADD;
        pkt_d.red_op   = valu_pkg::L_ADD;
        use_scalar     = 1'b0;

        case (op_i)
            valu_pkg::VADD_VV:     pkt_d.lane_op = valu_pkg::L_ADD;
            valu_pkg::VSUB_VV:     pkt_d.lane_op = valu_pkg::L_SUB;
            valu_pkg::VAND_VV:     pkt_d.lane_op = valu_pkg::L_AND;
            valu_pkg::VOR_VV:      pkt_d.lane_op = valu_pkg::L_OR;
            valu_pkg::VXOR_VV:     pkt_d.lane_op = valu_pkg::L_XOR;
            valu_pkg::VMIN_VV:     pkt_d.lane_op = valu_pkg::L_MIN;
            valu_pkg::VMAX_VV:     pkt_d.lane_op = valu_pkg::L_MAX;
            valu_pkg::VMUL_VV:     pkt_d.lane_op = valu_pkg::L_MUL;
            valu_pkg::VADD_VX: begin
                pkt_d.lane_op = valu_pkg::L_ADD;
                use_scalar    = 1'b1;
            end
            valu_pkg::VSUB_VX: begin
                pkt_d.lane_op = valu_pkg::L_SUB;
                use_scalar    = 1'b1;
            end
            valu_pkg::VMV_VV:      pkt_d.op_class = valu_pkg::C_MOVE;
            valu_pkg::VMV_VX: begin
                pkt_d.op_class = valu_pkg::C_MOVE;
                use_scalar     = 1'b1;
            end
            valu_pkg::VREDSUM: begin
                pkt_d.op_class = valu_pkg::C_REDUCE;
                pkt_d.red_op   = valu_pkg::L_ADD;
            end
            valu_pkg::VREDAND: begin
                pkt_d.op_class = valu_pkg::C_REDUCE;
                pkt_d.red_op   = valu_pkg::L_AND;
            end
            valu_pkg::VREDOR: begin
                pkt_d.op_class = valu_pkg::C_REDUCE;
                pkt_d.red_op   = valu_pkg::L_OR;
            end
            valu_pkg::VREDXOR: begin
                pkt_d.op_class = valu_pkg::C_REDUCE;
                pkt_d.red_op   = valu_pkg::L_XOR;
            end
            valu_pkg::VSLIDE1UP: begin
                pkt_d.op_class = valu_pkg::C_SLIDE;
                pkt_d.slide_up = 1'b1;
            end
            valu_pkg::VSLIDE1DOWN: pkt_d.op_class = valu_pkg::C_SLIDE;
            default:               pkt_d.lane_op  = valu_pkg::L_ADD;
        endcase

        pkt_d.valid          = valid_i;
        pkt_d.sew            = sew_i;
        pkt_d.first_operand  = first_operand_i;
        pkt_d.second_operand = use_scalar ? scalar_bcast : second_operand_i;
        pkt_d.scalar         = scalar_i;
    end

    ////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pkt_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            pkt_q <= pkt_d;
        end
    end

    always_comb begin
        pkt_o       = pkt_q;
        pkt_o.valid = valid_q;
    end

endmodule

// File: verilog/valu_exec.sv
/* Vector ALU execute stage
   Lanes, reduction and slide units with the result select and register */
`timescale 1ns/1ns

module valu_exec (
    input  logic                 clk,
    input  logic                 reset_n,
    input  valu_pkg::issue_pkt_t pkt_i,
    output logic                 valid_o,
    output valu_pkg::vec_t       result_o
);

    valu_pkg::vec_t lane_result;
    valu_pkg::vec_t reduce_result;
    valu_pkg::vec_t slide_result;
    valu_pkg::vec_t result_d;

    ////////////////////////////////////////
    // Units
    ////////////////////////////////////////
    for (genvar g = 0; g < valu_pkg::LANES; g++) begin : g_lane
        valu_lane u_lane (
            .lane_op_i (pkt_i.lane_op),
            .sew_i     (pkt_i.sew),
            .first_i   (pkt_i.first_operand[g*valu_pkg::LLEN +: valu_pkg::LLEN]),
            .second_i  (pkt_i.second_operand[g*valu_pkg::LLEN +: valu_pkg::LLEN]),
            .result_o  (lane_result[g*valu_pkg::LLEN +: valu_pkg::LLEN])
        );
    end

    valu_reduce u_reduce (
        .red_op_i (pkt_i.red_op),
        .sew_i    (pkt_i.sew),
        .vector_i (pkt_i.first_operand),
        .seed_i   (pkt_i.scalar),
        .result_o (reduce_result)
    );

    valu_slide u_slide (
        .slide_up_i (pkt_i.slide_up),
        .sew_i      (pkt_i.sew),
        .vector_i   (pkt_i.first_operand),
        .scalar_i   (pkt_i.scalar),
        .result_o   (slide_result)
    );

    ////////////////////////////////////////
    // Result select and register
    ////////////////////////////////////////
    // Moves take the second operand, already broadcast for the scalar form
    always_comb begin
        case (pkt_i.op_class)
            valu_pkg::C_MOVE:   result_d = pkt_i.second_operand;
            valu_pkg::C_REDUCE: result_d = reduce_result;
            valu_pkg::C_SLIDE:  result_d = slide_result;
            default:            result_d = lane_result;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o  <= 1'b0;
            result_o <= '0;
        end else begin
            valid_o <= pkt_i.valid;
            if (pkt_i.valid) begin
                result_o <= result_d;
            end
        end
    end

endmodule

// File: verilog/valu_top.sv
/* Vector ALU top level
   Issue stage feeding the execute stage, two cycles from input to result */
`timescale 1ns/1ns

module valu_top (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               valid_i,
    input  valu_pkg::valu_op_e op_i,
    input  valu_pkg::sew_e     sew_i,
    input  valu_pkg::vec_t     first_operand_i,
    input  valu_pkg::vec_t     second_operand_i,
    input  valu_pkg::scalar_t  scalar_i,
    output logic               valid_o,
    output valu_pkg::vec_t     result_o
);

    valu_pkg::issue_pkt_t issue_pkt;

    valu_issue u_issue (
        .clk              (clk),
        .reset_n          (reset_n),
        .valid_i          (valid_i),
        .op_i             (op_i),
        .sew_i            (sew_i),
        .first_operand_i  (first_operand_i),
        .second_operand_i (second_operand_i),
        .scalar_i         (scalar_i),
        .pkt_o            (issue_pkt)
    );

    valu_exec u_exec (
        .clk      (clk),
        .reset_n  (reset_n),
        .pkt_i    (issue_pkt),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

endmodule

// File: bench/valu_tests.svh
/* Vector ALU directed tests
   One task per behavior, each drains its results before reporting */

////////////////////////////////////////
// Element isolated add and subtract
////////////////////////////////////////
task automatic test_add_sub();
    int             err_start;
    valu_pkg::sew_e sew;

    err_start = errors;
    for (int k = 0; k < 3; k++) begin
        sew = valu_pkg::sew_e'(k);
        // All ones plus one in each byte, carries must stop at element edges
        issue_op(valu_pkg::VADD_VV, sew, '1, 64'h0101_0101_0101_0101, 32'h0);
        // Zero minus one, borrows must stop too
        issue_op(valu_pkg::VSUB_VV, sew, '0, 64'h0101_0101_0101_0101, 32'h0);
        issue_op(valu_pkg::VADD_VX, sew, 64'h7FFF_FFFF_FF7F_80FF, rand_vec(), 32'hFFFF_FF01);
        issue_op(valu_pkg::VSUB_VX, sew, '0, rand_vec(), 32'h0000_0001);
        issue_op(valu_pkg::VADD_VV, sew, rand_vec(), rand_vec(), $urandom);
        issue_op(valu_pkg::VSUB_VX, sew, rand_vec(), rand_vec(), $urandom);
    end
    drain();
    end_test("add_sub", err_start);
endtask

////////////////////////////////////////
// Logic, min/max and multiply
////////////////////////////////////////
task automatic test_logic_mul();
    int                 err_start;
    valu_pkg::sew_e     sew;
    valu_pkg::valu_op_e ops [6] = '{valu_pkg::VAND_VV, valu_pkg::VOR_VV, valu_pkg::VXOR_VV,
                                    valu_pkg::VMIN_VV, valu_pkg::VMAX_VV, valu_pkg::VMUL_VV};

    err_start = errors;
    for (int k = 0; k < 3; k++) begin
        sew = valu_pkg::sew_e'(k);
        for (int rep = 0; rep < 2; rep++) begin
            foreach (ops[j]) begin
                issue_op(ops[j], sew, rand_vec(), rand_vec(), $urandom);
            end
        end
        // Negative elements at every width
        issue_op(valu_pkg::VMIN_VV, sew, 64'h80FF_7F01_8000_FFFF, 64'h0180_FF7F_7FFF_0001,
                 32'h0);
        issue_op(valu_pkg::VMAX_VV, sew, 64'h80FF_7F01_8000_FFFF, 64'h0180_FF7F_7FFF_0001,
                 32'h0);
    end
    drain();
    end_test("logic_mul", err_start);
endtask

task automatic test_moves();
    int             err_start;
    valu_pkg::sew_e sew;

    err_start = errors;
    for (int k = 0; k < 3; k++) begin
        sew = valu_pkg::sew_e'(k);
        for (int rep = 0; rep < 2; rep++) begin
            issue_op(valu_pkg::VMV_VV, sew, rand_vec(), rand_vec(), $urandom);
            // Upper scalar bits set so a wide broadcast would show
            issue_op(valu_pkg::VMV_VX, sew, rand_vec(), rand_vec(), $urandom | 32'hA5A5_0000);
        end
    end
    drain();
    end_test("moves", err_start);
endtask

task automatic test_reduce();
    int                 err_start;
    valu_pkg::sew_e     sew;
    valu_pkg::valu_op_e reds [4] = '{valu_pkg::VREDSUM, valu_pkg::VREDAND,
                                     valu_pkg::VREDOR, valu_pkg::VREDXOR};

    err_start = errors;
    for (int k = 0; k < 3; k++) begin
        sew = valu_pkg::sew_e'(k);
        for (int rep = 0; rep < 2; rep++) begin
            foreach (reds[j]) begin
                issue_op(reds[j], sew, rand_vec(), rand_vec(), $urandom);
            end
        end
    end
    drain();
    end_test("reduce", err_start);
endtask

task automatic test_slide();
    int             err_start;
    valu_pkg::sew_e sew;

    err_start = errors;
    for (int k = 0; k < 3; k++) begin
        sew = valu_pkg::sew_e'(k);
        for (int rep = 0; rep < 2; rep++) begin
            issue_op(valu_pkg::VSLIDE1UP, sew, rand_vec(), rand_vec(), $urandom);
            issue_op(valu_pkg::VSLIDE1DOWN, sew, rand_vec(), rand_vec(), $urandom);
        end
    end
    drain();
    end_test("slide", err_start);
endtask

// Every cycle first, then with random idle cycles between operations
task automatic test_mixed();
    int err_start;

    err_start = errors;
    for (int k = 0; k < 24; k++) begin
        issue_op(valu_pkg::valu_op_e'($urandom_range(17, 0)),
                 valu_pkg::sew_e'($urandom_range(2, 0)), rand_vec(), rand_vec(), $urandom);
    end
    for (int k = 0; k < 24; k++) begin
        issue_op(valu_pkg::valu_op_e'($urandom_range(17, 0)),
                 valu_pkg::sew_e'($urandom_range(2, 0)), rand_vec(), rand_vec(), $urandom);
        repeat ($urandom_range(3, 0)) idle();
    end
    drain();
    end_test("mixed", err_start);
endtask

// File: bench/valu_tb.sv
/* Vector ALU testbench
   Directed tests against a reference model with an in-order scoreboard */
`timescale 1ns/1ns

module valu_tb;

    localparam int CLK_PERIOD = 4;
    localparam int SEED       = 32'h7582_403c;
    // Upper bound of operations issued by all tests together
    localparam int MAX_OPS    = 160;
    // Reset, up to four cycles per operation with gaps and drains, then a margin
    localparam int WATCHDOG_CYCLES = 10 + 4 * MAX_OPS + 100;

    typedef struct packed {
        valu_pkg::vec_t result;
        logic [31:0]    due;
    } exp_t;

    logic               clk;
    logic               reset_n;
    logic               valid_i;
    valu_pkg::valu_op_e op_i;
    valu_pkg::sew_e     sew_i;
    valu_pkg::vec_t     first_operand_i;
    valu_pkg::vec_t     second_operand_i;
    valu_pkg::scalar_t  scalar_i;
    logic               valid_o;
    valu_pkg::vec_t     result_o;

    exp_t exp_q[$];
    int   cyc    = 0;
    int   errors = 0;
    int   tests  = 0;

    valu_top dut_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .valid_i          (valid_i),
        .op_i             (op_i),
        .sew_i            (sew_i),
        .first_operand_i  (first_operand_i),
        .second_operand_i (second_operand_i),
        .scalar_i         (scalar_i),
        .valid_o          (valid_o),
        .result_o         (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic valu_pkg::vec_t ref_result(
        input valu_pkg::valu_op_e op,
        input valu_pkg::sew_e     sew,
        input valu_pkg::vec_t     a,
        input valu_pkg::vec_t     b,
        input valu_pkg::scalar_t  s
    );
        int             w;
        int             n;
        longint         mask;
        longint         half;
        longint         es;
        longint         ea;
        longint         eb;
        longint         sa;
        longint         sb;
        longint         r;
        longint         acc;
        valu_pkg::vec_t res;

        w    = (sew == valu_pkg::SEW8) ? 8 : (sew == valu_pkg::SEW16) ? 16 : 32;
        n    = valu_pkg::VLEN / w;
        mask = (longint'(1) << w) - 1;
        half = longint'(1) << (w - 1);
        es   = s & mask;
        acc  = es;
        res  = '0;
        for (int i = 0; i < n; i++) begin
            ea = (a >> (i * w)) & mask;
            eb = (b >> (i * w)) & mask;
            if (op == valu_pkg::VADD_VX || op == valu_pkg::VSUB_VX) begin
                eb = es;
            end
            // Sign extend from the element width for min and max
            sa = (ea ^ half) - half;
            sb = (eb ^ half) - half;
            r  = 0;
            case (op)
                valu_pkg::VADD_VV, valu_pkg::VADD_VX: r = ea + eb;
                valu_pkg::VSUB_VV, valu_pkg::VSUB_VX: r = ea - eb;
                valu_pkg::VAND_VV:     r = ea & eb;
                valu_pkg::VOR_VV:      r = ea | eb;
                valu_pkg::VXOR_VV:     r = ea ^ eb;
                valu_pkg::VMIN_VV:     r = (sa < sb) ? ea : eb;
                valu_pkg::VMAX_VV:     r = (sa > sb) ? ea : eb;
                valu_pkg::VMUL_VV:     r = ea * eb;
                valu_pkg::VMV_VV:      r = eb;
                valu_pkg::VMV_VX:      r = es;
                valu_pkg::VREDSUM:     acc = acc + ea;
                valu_pkg::VREDAND:     acc = acc & ea;
                valu_pkg::VREDOR:      acc = acc | ea;
                valu_pkg::VREDXOR:     acc = acc ^ ea;
                valu_pkg::VSLIDE1UP:   r = (i == 0) ? es : ((a >> ((i - 1) * w)) & mask);
                valu_pkg::VSLIDE1DOWN: r = (i == n - 1) ? es : ((a >> ((i + 1) * w)) & mask);
                default:               r = 0;
            endcase
            res = res | (valu_pkg::vec_t'(r & mask) << (i * w));
        end
        if (op inside {valu_pkg::VREDSUM, valu_pkg::VREDAND, valu_pkg::VREDOR,
                       valu_pkg::VREDXOR}) begin
            res = valu_pkg::vec_t'(acc & mask);
        end
        return res;
    endfunction

    task automatic compare(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
        if (got !== expected) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////
    function automatic valu_pkg::vec_t rand_vec();
        return {$urandom, $urandom};
    endfunction

    task automatic issue_op(input valu_pkg::valu_op_e op, input valu_pkg::sew_e sew,
                            input valu_pkg::vec_t a, input valu_pkg::vec_t b,
                            input valu_pkg::scalar_t s);
        exp_t e;

        @(posedge clk);
        valid_i          <= 1'b1;
        op_i             <= op;
        sew_i            <= sew;
        first_operand_i  <= a;
        second_operand_i <= b;
        scalar_i         <= s;
        // Sampled on the next edge, seen by the monitor two edges after that
        e.result = ref_result(op, sew, a, b, s);
        e.due    = cyc + 3;
        exp_q.push_back(e);
    endtask

    task automatic idle();
        @(posedge clk);
        valid_i <= 1'b0;
    endtask

    task automatic drain();
        idle();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        tests++;
        if (errors == err_start) begin
            $display("Test %s passed", name);
        end else begin
            $display("Test %s failed with %0d errors", name, errors - err_start);
        end
    endtask

    `include "valu_tests.svh"

    ////////////////////////////////////////
    // Scoreboard
    ////////////////////////////////////////
    // Reads outputs as they were before the edge
    always @(posedge clk) begin : monitor
        exp_t e;

        cyc <= cyc + 1;
        if (!reset_n) begin
            if (valid_o !== 1'b0) begin
                errors++;
                $display("valid_o is not low during reset");
            end
        end else if (valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("valid_o is high while no result is expected");
            end else begin
                e = exp_q.pop_front();
                compare("result_o", result_o, e.result);
                compare("valid_o cycle", 64'(cyc), 64'(e.due));
            end
        end else if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
            errors++;
            $display("valid_o is low when a result is due, result dropped");
            e = exp_q.pop_front();
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Done: errors found");
        $finish;
    end

    initial begin : main
        void'($urandom(SEED));
        // Reset edge lands after every process is waiting on it
        reset_n          <= 1'b0;
        valid_i          = 1'b0;
        op_i             = valu_pkg::VADD_VV;
        sew_i            = valu_pkg::SEW8;
        first_operand_i  = '0;
        second_operand_i = '0;
        scalar_i         = '0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;

        test_add_sub();
        test_logic_mul();
        test_moves();
        test_reduce();
        test_slide();
        test_mixed();

        repeat (4) @(posedge clk);
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+bench
verilog/valu_pkg.sv
verilog/valu_lane.sv
verilog/valu_reduce.sv
verilog/valu_slide.sv
verilog/valu_issue.sv
verilog/valu_exec.sv
verilog/valu_top.sv
bench/valu_tb.sv
